// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module dataCacheTb -o dataCacheSim

./obj_dir/dataCacheSim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// ==== sim.f ====
verilog/cacheGeomPkg.sv
verilog/cacheCtrlPkg.sv
verilog/tagArrayIf.sv
verilog/tagArray.sv
verilog/dataArray.sv
verilog/cacheController.sv
verilog/dataCache.sv
testbench/memoryModel.sv
testbench/dataCacheTb.sv

// ==== testbench/dataCacheTb.sv ====
`timescale 1ns/1ps

module dataCacheTb;

  localparam int memWords = 1024;
  localparam int opCount = 340;
  localparam int missCycles = 40;
  // Two full flushes with every set and way dirty
  localparam int flushCycles = 2 * (16 * 2 * 4 * 5 + 32);
  localparam int watchdogCycles = opCount * missCycles + flushCycles;
  localparam logic [31:0] seed = 32'h56e60cad;

  logic clk;
  logic reset;
  logic cpuRead;
  logic cpuWrite;
  logic [31:0] cpuAddr;
  logic [31:0] cpuWriteData;
  logic [3:0] cpuByteMask;
  logic [31:0] cpuReadData;
  logic stall;
  logic flush;
  logic memRequest;
  logic memWrite;
  logic [31:0] memAddr;
  logic [31:0] memWriteData;
  logic [31:0] memReadData;
  logic memReady;

  // Memory as the CPU sees it
  logic [31:0] refMem [memWords];
  logic [31:0] beatAddrs [$];
  logic [31:0] randState;
  int writeBeats;
  string testName;

  dataCache UUT (
    .clk          (clk),
    .reset        (reset),
    .cpuRead      (cpuRead),
    .cpuWrite     (cpuWrite),
    .cpuAddr      (cpuAddr),
    .cpuWriteData (cpuWriteData),
    .cpuByteMask  (cpuByteMask),
    .cpuReadData  (cpuReadData),
    .stall        (stall),
    .flush        (flush),
    .memRequest   (memRequest),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memReadData  (memReadData),
    .memReady     (memReady)
  );

  memoryModel #(.depth(memWords), .latencySeed(seed)) memModel (
    .clk          (clk),
    .reset        (reset),
    .memRequest   (memRequest),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memReadData  (memReadData),
    .memReady     (memReady)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    randState ^= randState << 13;
    randState ^= randState >> 17;
    randState ^= randState << 5;
    return randState;
  endfunction

  function automatic logic [31:0] makeAddr(input logic [3:0] tag, input logic [3:0] set,
                                           input logic [1:0] word);
    return {20'h0, tag, set, word, 2'b00};
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("Error in %s: expected %h, actual %h", name, expected, actual);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  // Hold the request until the first cycle with stall low
  task automatic access(input logic isWrite, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] mask, output int waited);
    waited = 0;
    @(posedge clk);
    #1;
    cpuRead = !isWrite;
    cpuWrite = isWrite;
    cpuAddr = addr;
    cpuWriteData = data;
    cpuByteMask = mask;
    @(negedge clk);
    while (stall) begin
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cpuRead = 1'b0;
    cpuWrite = 1'b0;
  endtask

  task automatic flushCache();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(negedge clk);
    while (stall) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  // Completed requests and bus write beats
  always @(negedge clk) begin
    if (!reset && cpuRead && !stall) begin
      assert (cpuReadData === refMem[cpuAddr[11:2]])
        else reportMismatch(testName, refMem[cpuAddr[11:2]], cpuReadData);
    end
    if (!reset && cpuWrite && !stall) begin
      for (int b = 0; b < 4; b++) begin
        if (cpuByteMask[b]) begin
          refMem[cpuAddr[11:2]][8*b +: 8] = cpuWriteData[8*b +: 8];
        end
      end
    end
    if (!reset && memRequest && memWrite && memReady) begin
      assert (memWriteData === refMem[memAddr[11:2]])
        else reportMismatch(testName, refMem[memAddr[11:2]], memWriteData);
      writeBeats++;
      beatAddrs.push_back(memAddr);
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Error: watchdog expired, the cache stopped answering");
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation hung");
  end

  initial begin
    int waited;
    int startBeats;
    logic [31:0] word;
    logic [31:0] r;
    clk = 1'b0;
    reset = 1'b1;
    cpuRead = 1'b0;
    cpuWrite = 1'b0;
    cpuAddr = '0;
    cpuWriteData = '0;
    cpuByteMask = '0;
    flush = 1'b0;
    randState = seed;
    writeBeats = 0;
    testName = "reset";
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      memModel.peekWord(i, word);
      refMem[i] = word;
    end

    testName = "read after write";
    access(1'b1, makeAddr(4'h1, 4'h2, 2'd1), 32'hcafef00d, 4'hf, waited);
    access(1'b1, makeAddr(4'h1, 4'h2, 2'd1), 32'h11223344, 4'b0101, waited);
    access(1'b0, makeAddr(4'h1, 4'h2, 2'd1), 32'h0, 4'h0, waited);

    testName = "hit without stall";
    access(1'b1, makeAddr(4'h3, 4'h7, 2'd2), 32'h0badbeef, 4'b1100, waited);
    access(1'b0, makeAddr(4'h3, 4'h7, 2'd2), 32'h0, 4'h0, waited);
    assert (waited == 0) else reportMismatch(testName, 0, waited);

    // A, B, A written in set 5, then C evicts B
    testName = "lru replacement";
    access(1'b1, makeAddr(4'h4, 4'h5, 2'd0), nextRandom(), 4'hf, waited);
    access(1'b1, makeAddr(4'h6, 4'h5, 2'd1), nextRandom(), 4'hf, waited);
    access(1'b1, makeAddr(4'h4, 4'h5, 2'd2), nextRandom(), 4'b0011, waited);
    beatAddrs.delete();
    access(1'b0, makeAddr(4'h8, 4'h5, 2'd3), 32'h0, 4'h0, waited);
    assert (beatAddrs.size() == 4) else reportMismatch(testName, 4, beatAddrs.size());
    for (int i = 0; i < 4; i++) begin
      assert (beatAddrs[i] == makeAddr(4'h6, 4'h5, 2'(i)))
        else reportMismatch(testName, makeAddr(4'h6, 4'h5, 2'(i)), beatAddrs[i]);
    end
    access(1'b0, makeAddr(4'h4, 4'h5, 2'd0), 32'h0, 4'h0, waited);
    assert (waited == 0) else reportMismatch(testName, 0, waited);

    // Clean victims are dropped without bus writes
    testName = "clean eviction";
    startBeats = writeBeats;
    access(1'b0, makeAddr(4'h1, 4'h9, 2'd0), 32'h0, 4'h0, waited);
    access(1'b0, makeAddr(4'h2, 4'h9, 2'd1), 32'h0, 4'h0, waited);
    access(1'b0, makeAddr(4'h3, 4'h9, 2'd2), 32'h0, 4'h0, waited);
    assert (writeBeats == startBeats) else reportMismatch(testName, startBeats, writeBeats);

    // Sets 0 to 3 only, so tags collide often
    testName = "random mix";
    for (int n = 0; n < 300; n++) begin
      r = nextRandom();
      word = nextRandom();
      access(r[0], makeAddr(r[7:4], {2'b00, r[9:8]}, r[11:10]), word,
             (r[15:12] == 4'h0) ? 4'hf : r[15:12], waited);
    end

    testName = "flush";
    flushCache();
    for (int i = 0; i < memWords; i++) begin
      memModel.peekWord(i, word);
      assert (word === refMem[i]) else reportMismatch(testName, refMem[i], word);
    end

    testName = "second flush";
    startBeats = writeBeats;
    flushCache();
    assert (writeBeats == startBeats) else reportMismatch(testName, startBeats, writeBeats);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== testbench/memoryModel.sv ====
`timescale 1ns/1ps

module memoryModel #(
  parameter int depth = 1024,
  parameter logic [31:0] latencySeed = 32'h1
) (
  input  logic clk,
  input  logic reset,
  input  logic memRequest,
  input  logic memWrite,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWriteData,
  output logic [31:0] memReadData,
  output logic memReady
);

  logic [31:0] words [depth];
  logic [31:0] randState;
  logic [1:0] waitLeft;
  logic counting;
  logic [9:0] wordIndex;

  assign wordIndex = memAddr[11:2];
  assign memReadData = words[wordIndex];

  function automatic logic [31:0] shuffleState(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Fill pattern mixes every address bit
  initial begin
    for (int i = 0; i < depth; i++) begin
      words[i] = (32'(i) * 32'h9e3779b1) ^ {i[15:0], 16'h5a5a};
    end
  end

  // Each beat waits 0 to 3 cycles before memReady
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      memReady <= 1'b0;
      counting <= 1'b0;
      waitLeft <= 2'd0;
      randState <= latencySeed;
    end else begin
      memReady <= 1'b0;
      if (memReady) begin
        // Beat completes at this edge
        counting <= 1'b0;
        if (memWrite) begin
          words[wordIndex] = memWriteData;
        end
      end else if (memRequest && !counting) begin
        randState <= shuffleState(randState);
        if (randState[1:0] == 2'd0) begin
          memReady <= 1'b1;
        end else begin
          counting <= 1'b1;
          waitLeft <= randState[1:0];
        end
      end else if (counting) begin
        waitLeft <= waitLeft - 2'd1;
        if (waitLeft == 2'd1) begin
          memReady <= 1'b1;
        end
      end
    end
  end

  task automatic peekWord(input int idx, output logic [31:0] value);
    value = words[idx];
  endtask

endmodule

// ==== verilog/cacheController.sv ====
`timescale 1ns/1ps

module cacheController (
  input  logic clk,
  input  logic reset,
  input  logic cpuRead,
  input  logic cpuWrite,
  input  logic [cacheGeomPkg::addrBits-1:0] cpuAddr,
  input  logic [3:0] cpuByteMask,
  input  logic flush,
  input  logic memReady,
  output logic stall,
  output logic memRequest,
  output logic memWrite,
  output logic [cacheGeomPkg::addrBits-1:0] memAddr,
  output logic [cacheGeomPkg::indexBits-1:0] dataIndex,
  output logic dataWay,
  output logic [cacheGeomPkg::offsetBits-1:0] dataWord,
  output logic [3:0] dataMask,
  output logic dataWriteEnable,
  output logic dataWriteSel,
  tagArrayIf.controller tags
);
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;

  cacheState state;
  cacheState nextState;
  logic [beatBits-1:0] beat;
  logic [indexBits-1:0] flushSet;

  logic [tagBits-1:0] addrTag;
  logic [indexBits-1:0] addrIndex;
  logic [offsetBits-1:0] addrOffset;
  logic [wayCount-1:0] wayHit;
  logic [tagBits-1:0] busTag;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic flushWay;
  logic busWay;
  logic anyDirty;
  logic lastSet;
  logic lastBeat;
  logic request;
  logic serveHit;
  logic inFlush;
  logic cpuSide;

  assign addrTag = cpuAddr[addrBits-1 -: tagBits];
  assign addrIndex = cpuAddr[offsetBits+2 +: indexBits];
  assign addrOffset = cpuAddr[2 +: offsetBits];
  assign request = cpuRead | cpuWrite;
  assign inFlush = (state == stFlushScan) || (state == stFlushWrite);
  assign cpuSide = (state == stReady) || (state == stRefillDone);

  // Walk counter replaces the address index during a flush
  assign tags.index = inFlush ? flushSet : addrIndex;

  always_comb begin
    for (int w = 0; w < wayCount; w++) begin
      wayHit[w] = tags.readValid[w] && (tags.readTag[w] == addrTag);
    end
  end

  assign hit = |wayHit;
  assign hitWay = wayHit[1];

  // Invalid way first, otherwise LRU
  assign victimWay = !tags.readValid[0] ? 1'b0 :
                     (!tags.readValid[1] ? 1'b1 : tags.lruWay);
  assign victimDirty = tags.readValid[victimWay] && tags.readDirty[victimWay];

  // Flush drains way 0 before way 1
  assign flushWay = !(tags.readValid[0] && tags.readDirty[0]);
  assign anyDirty = |(tags.readValid & tags.readDirty);
  assign lastSet = flushSet == indexBits'(setCount - 1);
  assign lastBeat = memReady && (beat == beatBits'(wordsPerBlock - 1));

  // Request answered this cycle
  assign serveHit = request && hit && ((state == stReady && !flush) ||
                                       state == stRefillDone);

  // Bus side
  assign busWay = inFlush ? flushWay : victimWay;
  assign busTag = (state == stRefill) ? addrTag : tags.readTag[busWay];
  assign memAddr = {busTag, tags.index, beat, 2'b00};
  assign memRequest = state inside {stWriteBack, stRefill, stFlushWrite};
  assign memWrite = state inside {stWriteBack, stFlushWrite};

  // Write-back beats read the array at the beat counter
  assign dataIndex = tags.index;
  assign dataWay = cpuSide ? hitWay : busWay;
  assign dataWord = cpuSide ? addrOffset : beat;
  assign dataWriteSel = state != stRefill;
  assign dataMask = (state == stRefill) ? 4'b1111 : cpuByteMask;
  assign dataWriteEnable = (serveHit && cpuWrite) || (state == stRefill && memReady);

  // Tag array updates
  assign tags.writeWay = serveHit ? hitWay : busWay;
  assign tags.fillEnable = (state == stRefill) && lastBeat;
  assign tags.fillTag = addrTag;
  assign tags.markDirty = serveHit && cpuWrite;
  assign tags.cleanEnable = (state == stFlushWrite) && lastBeat;
  assign tags.touchEnable = serveHit;
  assign tags.touchWay = hitWay;

  always_comb begin
    nextState = state;
    stall = 1'b1;
    case (state)
      stReady: begin
        if (flush) begin
          nextState = stFlushScan;
        end else if (request && !hit) begin
          nextState = victimDirty ? stWriteBack : stRefill;
        end else begin
          stall = 1'b0;
        end
      end
      stWriteBack: begin
        if (lastBeat) begin
          nextState = stRefill;
        end
      end
      stRefill: begin
        if (lastBeat) begin
          nextState = stRefillDone;
        end
      end
      // Block now resident, finish as a hit
      stRefillDone: begin
        stall = !hit;
        nextState = stReady;
      end
      stFlushScan: begin
        if (anyDirty) begin
          nextState = stFlushWrite;
        end else if (lastSet) begin
          nextState = stReady;
          stall = 1'b0;
        end
      end
      // Rescan the same set afterwards for the other way
      stFlushWrite: begin
        if (lastBeat) begin
          nextState = stFlushScan;
        end
      end
      default: nextState = stReady;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stReady;
      beat <= '0;
      flushSet <= '0;
    end else begin
      state <= nextState;
      // Wraps back to zero after the last beat
      if (memRequest && memReady) begin
        beat <= beat + 1'b1;
      end
      if (state == stReady) begin
        flushSet <= '0;
      end else if (state == stFlushScan && !anyDirty && !lastSet) begin
        flushSet <= flushSet + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/cacheCtrlPkg.sv ====
package cacheCtrlPkg;

  // Controller states
  typedef enum logic [2:0] {
    stReady,
    stWriteBack,
    stRefill,
    stRefillDone,
    stFlushScan,
    stFlushWrite
  } cacheState;

  // Beat counter covers one block
  localparam int beatBits = cacheGeomPkg::offsetBits;

endpackage

// ==== verilog/cacheGeomPkg.sv ====
package cacheGeomPkg;

  // Byte address width of the processor
  localparam int addrBits = 32;

  // Four words per block
  localparam int wordsPerBlock = 4;

  // Word offset in address bits 3 to 2
  localparam int offsetBits = 2;

  // Sixteen sets indexed by address bits 7 to 4
  localparam int setCount = 16;
  localparam int indexBits = 4;

  // Tag in address bits 31 to 8
  localparam int tagBits = 24;

  // Two-way associative
  localparam int wayCount = 2;

endpackage

// ==== verilog/dataArray.sv ====
`timescale 1ns/1ps

module dataArray (
  input logic clk,
  input logic [cacheGeomPkg::indexBits-1:0] dataIndex,
  input logic dataWay,
  input logic [cacheGeomPkg::offsetBits-1:0] dataWord,
  input logic [3:0] dataMask,
  input logic dataWriteEnable,
  input logic dataWriteSel,
  input logic [31:0] cpuWriteData,
  input logic [31:0] memReadData,
  output logic [31:0] readWord
);
  import cacheGeomPkg::*;

  logic [31:0] words [wayCount * setCount * wordsPerBlock];
  logic [indexBits+offsetBits:0] wordAddr;
  logic [31:0] writeWord;

  // Way, set and word form the flat word address
  assign wordAddr = {dataWay, dataIndex, dataWord};

  // High selects CPU store data, low selects refill data
  assign writeWord = dataWriteSel ? cpuWriteData : memReadData;

  assign readWord = words[wordAddr];

  // Byte-masked word write
  always_ff @(posedge clk) begin
    if (dataWriteEnable) begin
      for (int b = 0; b < 4; b++) begin
        if (dataMask[b]) begin
          words[wordAddr][8*b +: 8] <= writeWord[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/dataCache.sv ====
`timescale 1ns/1ps

module dataCache (
  input  logic clk,
  input  logic reset,
  input  logic cpuRead,
  input  logic cpuWrite,
  input  logic [cacheGeomPkg::addrBits-1:0] cpuAddr,
  input  logic [31:0] cpuWriteData,
  input  logic [3:0] cpuByteMask,
  output logic [31:0] cpuReadData,
  output logic stall,
  input  logic flush,
  output logic memRequest,
  output logic memWrite,
  output logic [cacheGeomPkg::addrBits-1:0] memAddr,
  output logic [31:0] memWriteData,
  input  logic [31:0] memReadData,
  input  logic memReady
);
  import cacheGeomPkg::*;

  logic [indexBits-1:0] dataIndex;
  logic dataWay;
  logic [offsetBits-1:0] dataWord;
  logic [3:0] dataMask;
  logic dataWriteEnable;
  logic dataWriteSel;
  logic [31:0] readWord;

  tagArrayIf tagBus ();

  tagArray tagStore (
    .clk   (clk),
    .reset (reset),
    .tags  (tagBus.array)
  );

  dataArray dataStore (
    .clk             (clk),
    .dataIndex       (dataIndex),
    .dataWay         (dataWay),
    .dataWord        (dataWord),
    .dataMask        (dataMask),
    .dataWriteEnable (dataWriteEnable),
    .dataWriteSel    (dataWriteSel),
    .cpuWriteData    (cpuWriteData),
    .memReadData     (memReadData),
    .readWord        (readWord)
  );

  cacheController controller (
    .clk             (clk),
    .reset           (reset),
    .cpuRead         (cpuRead),
    .cpuWrite        (cpuWrite),
    .cpuAddr         (cpuAddr),
    .cpuByteMask     (cpuByteMask),
    .flush           (flush),
    .memReady        (memReady),
    .stall           (stall),
    .memRequest      (memRequest),
    .memWrite        (memWrite),
    .memAddr         (memAddr),
    .dataIndex       (dataIndex),
    .dataWay         (dataWay),
    .dataWord        (dataWord),
    .dataMask        (dataMask),
    .dataWriteEnable (dataWriteEnable),
    .dataWriteSel    (dataWriteSel),
    .tags            (tagBus.controller)
  );

  // One read port serves load data and write-back data
  assign cpuReadData = readWord;
  assign memWriteData = readWord;

endmodule

// ==== verilog/tagArray.sv ====
`timescale 1ns/1ps

module tagArray (
  input logic clk,
  input logic reset,
  tagArrayIf.array tags
);
  import cacheGeomPkg::*;

  logic [tagBits-1:0] tagMem [wayCount][setCount];
  logic [wayCount-1:0][setCount-1:0] validBits;
  logic [wayCount-1:0][setCount-1:0] dirtyBits;

  // Way to replace next, per set
  logic [setCount-1:0] lruBits;

  // Combinational lookup of the addressed set
  always_comb begin
    for (int w = 0; w < wayCount; w++) begin
      tags.readTag[w] = tagMem[w][tags.index];
      tags.readValid[w] = validBits[w][tags.index];
      tags.readDirty[w] = dirtyBits[w][tags.index];
    end
  end

  assign tags.lruWay = lruBits[tags.index];

  // Tag storage
  always_ff @(posedge clk) begin
    if (tags.fillEnable) begin
      tagMem[tags.writeWay][tags.index] <= tags.fillTag;
    end
  end

  // Status bits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits <= '0;
    end else begin
      if (tags.fillEnable) begin
        validBits[tags.writeWay][tags.index] <= 1'b1;
        dirtyBits[tags.writeWay][tags.index] <= 1'b0;
      end
      if (tags.markDirty) begin
        dirtyBits[tags.writeWay][tags.index] <= 1'b1;
      end
      if (tags.cleanEnable) begin
        dirtyBits[tags.writeWay][tags.index] <= 1'b0;
      end
      // Point at the way not just used
      if (tags.touchEnable) begin
        lruBits[tags.index] <= ~tags.touchWay;
      end
    end
  end

endmodule

// ==== verilog/tagArrayIf.sv ====
`timescale 1ns/1ps

interface tagArrayIf;
  import cacheGeomPkg::*;

  logic [indexBits-1:0] index;

  // Lookup results for both ways
  logic [wayCount-1:0][tagBits-1:0] readTag;
  logic [wayCount-1:0] readValid;
  logic [wayCount-1:0] readDirty;
  logic lruWay;

  // Update controls
  logic writeWay;
  logic fillEnable;
  logic [tagBits-1:0] fillTag;
  logic markDirty;
  logic cleanEnable;
  logic touchEnable;
  logic touchWay;

  modport controller (
    output index, writeWay, fillEnable, fillTag, markDirty, cleanEnable,
    output touchEnable, touchWay,
    input readTag, readValid, readDirty, lruWay
  );

  modport array (
    input index, writeWay, fillEnable, fillTag, markDirty, cleanEnable,
    input touchEnable, touchWay,
    output readTag, readValid, readDirty, lruWay
  );

endinterface
